/* design/lenet_pe_settings.svh */
`ifndef LENET_PE_SETTINGS_SVH
`define LENET_PE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing for the convolution PE
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// activation/weight pairs taken per beat
`define LANES 4

// signed window accumulator
// a full-scale beat stays under 2^18, so 24 bits hold a 5x5 kernel in 7 beats
`define ACC_WIDTH 24

// signed per-channel bias
`define BIAS_WIDTH 16

// requantization shift amount
`define SHIFT_WIDTH 5

`endif

/* design/lenet_pe_pkg.sv */
`default_nettype none

`include "lenet_pe_settings.svh"

package lenet_pe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand and product widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0]         act_t;      // unsigned activation
    typedef logic [7:0]         wmag_t;     // weight magnitude, sign travels apart
    typedef logic [15:0]        prod_t;     // approximate unsigned product
    typedef logic signed [16:0] sprod_t;    // product with the weight sign applied
    typedef logic signed [18:0] lane_sum_t; // sum of the four lanes of one beat

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accumulation and requantization
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [`ACC_WIDTH-1:0]  acc_t;
    typedef logic signed [`BIAS_WIDTH-1:0] bias_t;
    typedef logic [`SHIFT_WIDTH-1:0]       shift_t;
    typedef logic [7:0]                    pixel_t;  // output pixel after saturation

    typedef enum logic {
        RQ_IDLE,
        RQ_EMIT    // pixel register holds a fresh result
    } rq_state_t;

endpackage

`default_nettype wire

/* design/pe_beat_if.sv */
`default_nettype none

`include "lenet_pe_settings.svh"

interface pe_beat_if;
    import lenet_pe_pkg::*;

    logic                   valid;  // beat present this cycle
    logic                   first;  // opening beat of a kernel window
    logic                   last;   // closing beat of a kernel window
    act_t  [`LANES-1:0]     act;
    wmag_t [`LANES-1:0]     wmag;
    logic  [`LANES-1:0]     wsign;  // set means the lane weight is negative

    // the accumulator only ever reads a beat
    modport sink (
        input valid,
        input first,
        input last,
        input act,
        input wmag,
        input wsign
    );

endinterface

`default_nettype wire

/* design/approx_mult_8x8.sv */
`default_nettype none

module approx_mult_8x8 (
    input  lenet_pe_pkg::act_t  x,
    input  lenet_pe_pkg::wmag_t y,
    output lenet_pe_pkg::prod_t z
);
    import lenet_pe_pkg::*;

    wmag_t       pp [8];  // pp[k] is y gated by x[k]
    logic [12:0] row1;
    logic [12:0] row2;
    logic [12:0] row3;
    logic [12:0] row4;
    logic [12:0] row5;

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            pp[k] = y & {8{x[k]}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pruned low rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rows 0..5 are folded pairwise into five sparse 13-bit rows
    always_comb begin
        row1     = '0;
        row1[2]  = pp[2][0];
        row1[4]  = pp[0][4] ^ pp[1][3];
        row1[6]  = pp[4][1] ^ pp[5][0];
        row1[7]  = pp[0][6] | pp[1][5];
        row1[8]  = pp[1][7];
        row1[9]  = pp[2][7] | pp[3][6];
        row1[10] = pp[2][7] & pp[3][6];   // carry of the OR above
        row1[11] = pp[4][7] & pp[5][6];
        row1[12] = pp[5][7];
    end

    always_comb begin
        row2     = '0;
        row2[7]  = pp[0][7] | pp[1][6];
        row2[8]  = pp[2][5] & pp[3][4];
        row2[9]  = pp[4][4] & pp[5][3];
        row2[10] = pp[3][7];
        row2[11] = pp[4][7] | pp[5][6];
    end

    always_comb begin
        row3     = '0;
        row3[7]  = pp[2][4] | pp[3][3];
        row3[8]  = pp[2][6] & pp[3][5];
        row3[9]  = pp[4][5] & pp[5][4];
        row3[10] = pp[4][6] & pp[5][5];
    end

    // xor/or halves of the pairs whose and terms sit in row2 and row3
    always_comb begin
        row4     = '0;
        row4[7]  = pp[2][5] ^ pp[3][4];
        row4[8]  = pp[2][6] | pp[3][5];
        row4[9]  = pp[4][5] | pp[5][4];
        row4[10] = pp[4][6] | pp[5][5];
    end

    always_comb begin
        row5     = '0;
        row5[7]  = pp[4][3] ^ pp[5][2];
        row5[8]  = pp[4][4] ^ pp[5][3];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // final adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the two top rows stay exact, the sum wraps at 16 bits
    assign z = prod_t'({pp[6], 6'b0}) + prod_t'({pp[7], 7'b0})
             + prod_t'(row1) + prod_t'(row2) + prod_t'(row3)
             + prod_t'(row4) + prod_t'(row5);

endmodule

`default_nettype wire

/* design/window_mac.sv */
`default_nettype none

`include "lenet_pe_settings.svh"

module window_mac (
    input  logic                clk,
    input  logic                rst_n,
    pe_beat_if.sink             beat,
    output logic                acc_done,
    output lenet_pe_pkg::acc_t  acc_sum
);
    import lenet_pe_pkg::*;

    // captured beat
    logic                   in_valid;
    logic                   in_first;
    logic                   in_last;
    act_t  [`LANES-1:0]     in_act;
    wmag_t [`LANES-1:0]     in_wmag;
    logic  [`LANES-1:0]     in_wsign;

    prod_t                  prod [`LANES];

    // stage 1
    logic                   s1_valid;
    logic                   s1_first;
    logic                   s1_last;
    sprod_t                 s1_prod [`LANES];

    lane_sum_t              lane_sum;
    acc_t                   acc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beat capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
            in_first <= 1'b0;
            in_last  <= 1'b0;
        end else begin
            in_valid <= beat.valid;
            in_first <= beat.valid & beat.first;
            in_last  <= beat.valid & beat.last;
        end
    end

    always_ff @(posedge clk) begin
        in_act   <= beat.act;
        in_wmag  <= beat.wmag;
        in_wsign <= beat.wsign;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // multiplier lanes and sign application
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < `LANES; g++) begin : g_lane
        approx_mult_8x8 i_mult (
            .x (in_act[g]),
            .y (in_wmag[g]),
            .z (prod[g])
        );

        always_ff @(posedge clk) begin
            if (in_wsign[g]) begin
                s1_prod[g] <= -sprod_t'({1'b0, prod[g]});
            end else begin
                s1_prod[g] <= sprod_t'({1'b0, prod[g]});
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s1_first <= in_first;
            s1_last  <= in_last;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane sum and window accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `LANES; i++) begin
            lane_sum = lane_sum + lane_sum_t'(s1_prod[i]);  // sign extends each lane
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            if (s1_first) begin
                acc <= acc_t'(lane_sum);        // opening beat drops the previous window
            end else begin
                acc <= acc + acc_t'(lane_sum);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_done <= 1'b0;
        end else begin
            acc_done <= s1_valid & s1_last;    // acc settles on this same edge
        end
    end

    assign acc_sum = acc;

endmodule

`default_nettype wire

/* design/relu_requant.sv */
`default_nettype none

module relu_requant (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_done,
    input  lenet_pe_pkg::acc_t    acc_sum,
    input  lenet_pe_pkg::bias_t   bias,
    input  lenet_pe_pkg::shift_t  shift,
    output logic                  out_valid,
    output lenet_pe_pkg::pixel_t  pixel_out
);
    import lenet_pe_pkg::*;

    localparam int SUM_W = $bits(acc_t) + 1;  // one guard bit for the bias add

    logic signed [SUM_W-1:0] biased;
    logic [SUM_W-1:0]        shifted;
    pixel_t                  pixel_next;
    rq_state_t               state;
    rq_state_t               state_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bias, relu, shift and clip
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        biased  = SUM_W'(acc_sum) + SUM_W'(bias);
        shifted = $unsigned(biased) >> shift;    // only used when biased is non-negative
        if (biased < 0) begin
            pixel_next = '0;
        end else if (shifted > SUM_W'(255)) begin
            pixel_next = 8'hff;
        end else begin
            pixel_next = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done) begin
            pixel_out <= pixel_next;
        end
    end

    // back to back windows keep the machine in RQ_EMIT
    assign state_next = acc_done ? RQ_EMIT : RQ_IDLE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign out_valid = (state == RQ_EMIT);

endmodule

`default_nettype wire

/* design/lenet_pe_top.sv */
`default_nettype none

`include "lenet_pe_settings.svh"

module lenet_pe_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic                                in_first,
    input  logic                                in_last,
    input  lenet_pe_pkg::act_t  [`LANES-1:0]    act_in,
    input  lenet_pe_pkg::wmag_t [`LANES-1:0]    wmag_in,
    input  logic                [`LANES-1:0]    wsign_in,
    input  lenet_pe_pkg::bias_t                 bias,
    input  lenet_pe_pkg::shift_t                shift,
    output logic                                out_valid,
    output lenet_pe_pkg::pixel_t                pixel_out
);
    import lenet_pe_pkg::*;

    logic acc_done;
    acc_t acc_sum;

    pe_beat_if i_beat_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input beat onto the interface
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign i_beat_if.valid = in_valid;
    assign i_beat_if.first = in_first;
    assign i_beat_if.last  = in_last;
    assign i_beat_if.act   = act_in;
    assign i_beat_if.wmag  = wmag_in;
    assign i_beat_if.wsign = wsign_in;

    // three edges from a sampled last beat to out_valid
    window_mac i_window_mac (
        .clk      (clk),
        .rst_n    (rst_n),
        .beat     (i_beat_if.sink),
        .acc_done (acc_done),
        .acc_sum  (acc_sum)
    );

    relu_requant i_relu_requant (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_done  (acc_done),
        .acc_sum   (acc_sum),
        .bias      (bias),
        .shift     (shift),
        .out_valid (out_valid),
        .pixel_out (pixel_out)
    );

endmodule

`default_nettype wire

/* bench/lenet_pe_tb.sv */
`default_nettype none

`include "lenet_pe_settings.svh"

module lenet_pe_tb;
    import lenet_pe_pkg::*;

    localparam int MAX_REC = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_first;
    logic                 in_last;
    act_t  [`LANES-1:0]   act_in;
    wmag_t [`LANES-1:0]   wmag_in;
    logic  [`LANES-1:0]   wsign_in;
    bias_t                bias;
    shift_t               shift;
    logic                 out_valid;
    pixel_t               pixel_out;

    logic [103:0]         rec_mem [MAX_REC];  // ctrl, act, wmag, bias, shift, expected
    pixel_t               exp_q[$];
    int                   due_q[$];           // cycle at which each pixel is due
    int                   n_rec;
    int                   n_last;
    int                   pix_seen;
    int                   cycle;
    int                   limit;
    integer               seed;

    lenet_pe_top i_lenet_pe_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_last   (in_last),
        .act_in    (act_in),
        .wmag_in   (wmag_in),
        .wsign_in  (wsign_in),
        .bias      (bias),
        .shift     (shift),
        .out_valid (out_valid),
        .pixel_out (pixel_out)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // failure handling and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("FAIL pixel_out got 0x%h expected 0x%h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("FAIL out_valid cycle got 0x%h expected 0x%h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            $display("FAIL out_valid count got 0x%h expected 0x%h", got, exp);
            stop_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle counter and output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > limit) begin
            $display("run exceeded %0d cycles without finishing", limit);
            stop_run();
        end
    end

    always @(negedge clk) begin : monitor
        pixel_t exp_pix;
        int     due;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid pulsed with no window outstanding");
                stop_run();
            end else begin
                exp_pix = exp_q.pop_front();
                due     = due_q.pop_front();
                check_pixel(pixel_out, exp_pix);
                check_latency(cycle, due);
                pix_seen++;
            end
        end
    end

    task automatic drive_idle();
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [7:0] ctrl;
        bias_t      rec_bias;
        shift_t     rec_shift;
        int         gap;
        clk      = 1'b0;
        rst_n    = 1'b0;
        act_in   = '0;
        wmag_in  = '0;
        wsign_in = '0;
        bias     = '0;
        shift    = '0;
        drive_idle();
        cycle    = 0;
        limit    = MAX_REC * 4 + 50;
        n_last   = 0;
        pix_seen = 0;
        seed     = 32'h3e69;

        $readmemh("bench/lenet_pe_testdata.mem", rec_mem);
        n_rec = 0;
        while (n_rec < MAX_REC && rec_mem[n_rec][99] == 1'b0) begin
            n_rec++;
        end
        if (n_rec == MAX_REC || n_rec == 0) begin
            $display("test data file has no records or no end marker");
            stop_run();
        end
        limit = n_rec * 4 + 50;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_rec; i++) begin
            ctrl      = rec_mem[i][103:96];
            rec_bias  = rec_mem[i][31:16];
            rec_shift = rec_mem[i][12:8];
            gap       = $random(seed) & 3;
            repeat (gap) begin
                @(negedge clk);
                drive_idle();
            end
            // bias and shift only change once earlier windows have left the pipeline
            if (ctrl[0] && (rec_bias != bias || rec_shift != shift)) begin
                while (exp_q.size() != 0) begin
                    @(negedge clk);
                    drive_idle();
                end
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_first = ctrl[0];
            in_last  = ctrl[1];
            wsign_in = ctrl[7:4];
            act_in   = rec_mem[i][95:64];
            wmag_in  = rec_mem[i][63:32];
            bias     = rec_bias;
            shift    = rec_shift;
            if (ctrl[1]) begin
                exp_q.push_back(rec_mem[i][7:0]);
                due_q.push_back(cycle + 4);    // sampled on the next edge, out three later
                n_last++;
            end
        end

        @(negedge clk);
        drive_idle();
        repeat (8) @(negedge clk);    // the last pixel is due early, the rest catches stray pulses
        check_count(pix_seen, n_last);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/lenet_pe_testdata.mem */
// ctrl_act_wmag_bias_shift_expected, lane 0 in the low byte of act and wmag
// ctrl bit0 first, bit1 last, bit3 end of data, bits 7..4 weight signs of lanes 3..0
// single-beat windows, one lane each, bias and shift zero
03_00000001_00000003_0000_00_00
03_00000400_00001000_0000_00_80
03_00020000_000f0000_0000_00_10
03_10000000_02000000_0000_00_40
03_00000020_00000001_0000_00_40
03_00004000_00000300_0000_00_c0
03_00800000_00050000_0000_00_ff
03_08000000_01000000_0000_00_00
03_00000004_00000001_0000_00_04
// three beats, mixed signs, sum 2448 plus 100 shifted by 4
a1_04c04080_10032010_0064_04_00
20_20008080_0100f0ff_0064_04_00
12_00100240_00020f01_0064_04_9f
// two beats, sum 1940 plus 100 shifted by 4
11_0140c080_10402040_0064_04_00
12_00000440_00000502_0064_04_7f
// single beat that saturates
23_00008080_00000880_0064_04_ff
// bias of -200 pushes the sum below zero
01_00008040_00000101_ff38_00_00
42_01040000_10100000_ff38_00_00
// same bias, sum 320 gives 120
23_00004080_00000103_ff38_00_78
// large negative window followed by a small positive one
11_00000080_000000ff_0000_02_00
20_0000c000_0000ff00_0000_02_00
02_00400000_00010000_0000_02_00
03_40000000_04000000_0000_02_40
// four beats, sum 192 plus 1024 shifted by 3
c1_01081020_03010203_0400_03_00
10_00000080_00000002_0400_03_00
00_0000c000_00000100_0400_03_00
02_04000000_10000000_0400_03_98
// widest shift drops everything
03_00000080_000000ff_ffff_1f_00
// all lanes at full scale with the largest bias
03_c0c0c0c0_ffffffff_7fff_10_03
// end of data
08_00000000_00000000_0000_00_00

/* compile.f */
+incdir+design
design/lenet_pe_pkg.sv
design/pe_beat_if.sv
design/approx_mult_8x8.sv
design/window_mac.sv
design/relu_requant.sv
design/lenet_pe_top.sv
bench/lenet_pe_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module lenet_pe_tb \
    -f compile.f

./obj_dir/Vlenet_pe_tb
